//--- source/uart_pkg.sv
package uart_pkg;

   // One frame on the line is start, eight data bits, parity and stop.
   localparam int FRAME_BITS = 11;
   localparam int DATA_BITS  = 8;

   // Line levels shared by the transmitter and the receiver.
   localparam logic LINE_IDLE = 1'b1;
   localparam logic START_BIT = 1'b0;
   localparam logic STOP_BIT  = 1'b1;

   // The shift registers move the frame as a plain vector, while the framing
   // logic builds and checks it by field.
   // Members of a packed struct are listed from the top bit down, so start
   // lands in bit 0. Shifting raw right therefore sends the frame in line order.
   typedef union packed {
      logic [FRAME_BITS-1:0] raw;
      struct packed {
         logic                 stop;
         logic                 parity;
         logic [DATA_BITS-1:0] data;
         logic                 start;
      } fields;
   } uart_frame_t;

   // Odd parity over the data byte.
   // The returned bit makes the number of ones in data plus parity odd.
   function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
      return ~^data;
   endfunction

endpackage

//--- source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] cmd_in,
   input  logic        cmd_vld,
   output logic        cmd_rdy,
   output logic        tx
);

   localparam int TX_BITS = 2 * FRAME_BITS; // Two frames per command.
   localparam int TIMER_W = $clog2(CLKS_PER_BIT);
   localparam int COUNT_W = $clog2(TX_BITS);

   localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(CLKS_PER_BIT - 1);
   localparam logic [COUNT_W-1:0] COUNT_LAST = COUNT_W'(TX_BITS - 1);

   logic               busy;
   logic [TIMER_W-1:0] bit_timer;
   logic [COUNT_W-1:0] bit_cnt;
   logic [TX_BITS-1:0] shift_reg;
   logic [TX_BITS-1:0] shift_next;
   logic [TX_BITS-1:0] load_word;
   uart_frame_t        hi_frame;
   uart_frame_t        lo_frame;
   logic               accept;
   logic               bit_end;
   logic               last_bit;

   function automatic uart_frame_t make_frame(input logic [DATA_BITS-1:0] data);
      uart_frame_t frame;
      frame.fields.start  = START_BIT;
      frame.fields.data   = data;
      frame.fields.parity = odd_parity(data);
      frame.fields.stop   = STOP_BIT;
      return frame;
   endfunction

   assign hi_frame = make_frame(cmd_in[15:8]);
   assign lo_frame = make_frame(cmd_in[7:0]);

   // High byte frame sits in the lower half and goes out first.
   assign load_word  = {lo_frame.raw, hi_frame.raw};
   assign shift_next = {LINE_IDLE, shift_reg[TX_BITS-1:1]};

   assign cmd_rdy  = ~busy;
   assign accept   = cmd_vld & cmd_rdy;
   assign bit_end  = busy && (bit_timer == TIMER_LAST);
   assign last_bit = (bit_cnt == COUNT_LAST);

   // The start bit is driven on the acceptance edge, so the first bit gets
   // its full time before the first shift.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         bit_timer <= '0;
         bit_cnt   <= '0;
         tx        <= LINE_IDLE;
      end else if (accept) begin
         busy      <= 1'b1;
         bit_timer <= '0;
         bit_cnt   <= '0;
         tx        <= load_word[0];
      end else if (busy) begin
         if (bit_end) begin
            bit_timer <= '0;
            if (last_bit) begin
               busy <= 1'b0; // Second stop bit has run its full time.
               tx   <= LINE_IDLE;
            end else begin
               bit_cnt <= bit_cnt + COUNT_W'(1);
               tx      <= shift_next[0];
            end
         end else begin
            bit_timer <= bit_timer + TIMER_W'(1);
         end
      end
   end

   // tx always carries bit bit_cnt of the loaded word.
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_reg <= load_word;
      end else if (bit_end) begin
         shift_reg <= shift_next;
      end
   end

endmodule

//--- source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
   import uart_pkg::*;
#(
   parameter int CLKS_PER_BIT = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rx,
   output logic [DATA_BITS-1:0] read_data,
   output logic                 read_rdy,
   output logic                 read_err
);

   localparam int TIMER_W = $clog2(CLKS_PER_BIT);

   localparam logic [TIMER_W-1:0] HALF_LAST = TIMER_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [TIMER_W-1:0] BIT_LAST  = TIMER_W'(CLKS_PER_BIT - 1);

   // Data bits plus parity are sampled in the bits state.
   localparam logic [3:0] PAYLOAD_LAST = 4'(DATA_BITS);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_START = 2'd1;
   localparam logic [1:0] ST_BITS  = 2'd2;
   localparam logic [1:0] ST_STOP  = 2'd3;

   logic               rx_meta;
   logic               rx_sync;
   logic [1:0]         state;
   logic [TIMER_W-1:0] timer;
   logic [3:0]         bit_cnt;
   uart_frame_t        frame;
   uart_frame_t        frame_next;
   logic               sample;
   logic               frame_ok;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= LINE_IDLE;
         rx_sync <= LINE_IDLE;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   // Half a bit to reach the start midpoint, then one full bit per sample.
   always_comb begin
      case (state)
         ST_START: sample = (timer == HALF_LAST);
         ST_BITS,
         ST_STOP:  sample = (timer == BIT_LAST);
         default:  sample = 1'b0;
      endcase
   end

   // Each sample enters at the top, so after the stop sample the start bit
   // has reached bit 0.
   assign frame_next.raw = {rx_sync, frame.raw[FRAME_BITS-1:1]};

   assign frame_ok = (frame_next.fields.stop == STOP_BIT) &&
                     (frame_next.fields.parity == odd_parity(frame_next.fields.data));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         timer     <= '0;
         bit_cnt   <= '0;
         read_data <= '0;
         read_rdy  <= 1'b0;
         read_err  <= 1'b0;
      end else begin
         read_rdy <= 1'b0;
         read_err <= 1'b0;
         if (state == ST_IDLE || sample) begin
            timer <= '0;
         end else begin
            timer <= timer + TIMER_W'(1);
         end
         case (state)
            ST_IDLE: begin
               if (rx_sync == START_BIT) begin
                  state <= ST_START;
               end
            end
            ST_START: begin
               if (sample) begin
                  bit_cnt <= '0;
                  // A high level at the midpoint was only a glitch.
                  state   <= (rx_sync == START_BIT) ? ST_BITS : ST_IDLE;
               end
            end
            ST_BITS: begin
               if (sample) begin
                  bit_cnt <= bit_cnt + 4'd1;
                  if (bit_cnt == PAYLOAD_LAST) begin
                     state <= ST_STOP;
                  end
               end
            end
            ST_STOP: begin
               if (sample) begin
                  state <= ST_IDLE; // The next start edge can be taken at once.
                  if (frame_ok) begin
                     read_data <= frame_next.fields.data;
                     read_rdy  <= 1'b1;
                  end else begin
                     read_err  <= 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (sample) begin
         frame <= frame_next;
      end
   end

endmodule

//--- source/uart.sv
`timescale 1ns/1ps

module uart #(
   parameter int CLKS_PER_BIT = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] cmd_in,
   input  logic        cmd_vld,
   output logic        cmd_rdy,
   output logic        tx,
   input  logic        rx,
   output logic [7:0]  read_data,
   output logic        read_rdy,
   output logic        read_err
);

   // Both sides run from the same bit time. Any loopback is made outside.
   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .read_err  (read_err)
   );

endmodule

//--- testbench/uart_assert.sv
`timescale 1ns/1ps

module uart_assert #(
   parameter int CLKS_PER_BIT = 4
) (
   input logic        clk,
   input logic        rst_n,
   input logic [15:0] cmd_in,
   input logic        cmd_vld,
   input logic        cmd_rdy,
   input logic        tx,
   input logic        read_rdy,
   input logic        read_err
);

   localparam int TX_CYCLES = 22 * CLKS_PER_BIT;

   int          low_cnt; // Low cycles of cmd_rdy since the last acceptance.
   int          fail_cnt = 0;
   logic        rdy_q;
   logic        vld_q;
   logic [15:0] cmd_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         low_cnt <= 0;
         rdy_q   <= 1'b1;
         vld_q   <= 1'b0;
         cmd_q   <= '0;
      end else begin
         if (cmd_vld && cmd_rdy) begin
            low_cnt <= 0;
         end else if (!cmd_rdy) begin
            low_cnt <= low_cnt + 1;
         end
         rdy_q <= cmd_rdy;
         vld_q <= cmd_vld;
         cmd_q <= cmd_in;
      end
   end

   a_rdy_low_max: assert property (@(posedge clk) disable iff (!rst_n)
      !cmd_rdy |-> (low_cnt < TX_CYCLES))
      else begin
         $error("cmd_rdy stayed low past the end of the second frame");
         fail_cnt++;
      end

   // A rising cmd_rdy must come exactly at the end of the second stop bit.
   a_rdy_low_len: assert property (@(posedge clk) disable iff (!rst_n)
      (cmd_rdy && !rdy_q) |-> (low_cnt == TX_CYCLES))
      else begin
         $error("cmd_rdy rose after %0d low cycles", low_cnt);
         fail_cnt++;
      end

   a_rx_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(read_rdy && read_err))
      else begin
         $error("read_rdy and read_err high together");
         fail_cnt++;
      end

   a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      read_rdy |=> !read_rdy)
      else begin
         $error("read_rdy longer than one cycle");
         fail_cnt++;
      end

   a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      read_err |=> !read_err)
      else begin
         $error("read_err longer than one cycle");
         fail_cnt++;
      end

   a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_rdy |-> tx)
      else begin
         $error("tx low while the transmitter is idle");
         fail_cnt++;
      end

   // A waiting command must not change under the source's hands.
   a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (cmd_vld && vld_q && !rdy_q) |-> (cmd_in == cmd_q))
      else begin
         $error("cmd_in changed while waiting for cmd_rdy");
         fail_cnt++;
      end

endmodule

bind uart uart_assert #(
   .CLKS_PER_BIT (CLKS_PER_BIT)
) u_assert (
   .clk      (clk),
   .rst_n    (rst_n),
   .cmd_in   (cmd_in),
   .cmd_vld  (cmd_vld),
   .cmd_rdy  (cmd_rdy),
   .tx       (tx),
   .read_rdy (read_rdy),
   .read_err (read_err)
);

//--- testbench/uart_tb.sv
`timescale 1ns/1ps

module uart_tb
   import uart_pkg::*;
();

   localparam int CLKS_PER_BIT = 4;
   localparam int TX_CYCLES    = 2 * FRAME_BITS * CLKS_PER_BIT;
   localparam int LINE_TIMEOUT = 4 * FRAME_BITS * CLKS_PER_BIT;
   localparam int SEED         = 35151;

   // One receive result as seen on the DUT outputs.
   typedef struct packed {
      logic       err;
      logic [7:0] data;
   } rx_event_t;

   logic        clk;
   logic        rst_n;
   logic [15:0] cmd_in;
   logic        cmd_vld;
   logic        cmd_rdy;
   logic        tx;
   logic        rx;
   logic        rx_line;
   logic        loopback;
   logic [7:0]  read_data;
   logic        read_rdy;
   logic        read_err;

   int          errors = 0;
   int          checks = 0;
   int          tests  = 0;
   logic [7:0]  exp_tx_q[$];
   rx_event_t   exp_rx_q[$];
   rx_event_t   got_rx_q[$];

   uart #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx),
      .read_data (read_data),
      .read_rdy  (read_rdy),
      .read_err  (read_err)
   );

   assign rx = loopback ? tx : rx_line;

   always #50 clk = ~clk;

   // Every receive pulse is logged; the tests compare the log in order.
   always @(negedge clk) begin
      if (rst_n && (read_rdy || read_err)) begin
         got_rx_q.push_back({read_err, read_data});
      end
   end

   function automatic int count_ones(input logic [7:0] value);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         ones += int'(value[i]);
      end
      return ones;
   endfunction

   task automatic check_val(input string sig, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("CHECK FAILED %s: got %0h, expected %0h", sig, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - errs_before);
      end
   endtask

   // Offers one command and measures how long cmd_rdy stays low. With inject
   // set, one-cycle cmd_vld pulses carrying other data are sent while busy.
   task automatic send_cmd(input logic [15:0] cmd, input bit inject);
      int cycles;
      cycles = 0;
      while (!cmd_rdy && cycles < LINE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (!cmd_rdy) begin
         $display("timeout waiting for cmd_rdy before a new command");
         errors++;
         return;
      end
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(negedge clk); // The acceptance edge has passed.
      cmd_vld = 1'b0;
      cycles  = 0;
      while (!cmd_rdy && cycles < LINE_TIMEOUT) begin
         if (inject && !cmd_vld && cycles < TX_CYCLES - 2 && $urandom_range(0, 5) == 0) begin
            cmd_in  = cmd ^ (16'($urandom) | 16'h0001);
            cmd_vld = 1'b1;
         end else begin
            cmd_vld = 1'b0;
         end
         @(negedge clk);
         cycles++;
      end
      cmd_vld = 1'b0;
      if (!cmd_rdy) begin
         $display("timeout waiting for cmd_rdy to return after a command");
         errors++;
      end else begin
         check_val("cmd_rdy low cycles", cycles, TX_CYCLES);
      end
   endtask

   // Line decoder for tx. Samples at the negedges closest to each bit middle.
   task automatic decode_tx_frame(output logic [7:0] data, output bit found);
      logic [FRAME_BITS-1:0] bits;
      int                    wait_cnt;
      int                    i;
      found    = 1'b0;
      data     = '0;
      bits     = '0;
      wait_cnt = 0;
      do begin
         @(negedge clk);
         wait_cnt++;
      end while (tx !== 1'b0 && wait_cnt < LINE_TIMEOUT);
      if (tx !== 1'b0) begin
         $display("timeout waiting for a start bit on tx");
         errors++;
         return;
      end
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (i = 0; i < FRAME_BITS; i++) begin
         if (i > 0) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
         end
         bits[i] = tx;
      end
      data = bits[8:1];
      check_val("tx start bit", bits[0], 0);
      check_val("tx parity bit", bits[9], (count_ones(data) % 2 == 0) ? 1 : 0);
      check_val("tx stop bit", bits[10], 1);
      found = 1'b1;
   endtask

   task automatic expect_cmd_frames();
      logic [7:0] data;
      logic [7:0] exp;
      bit         found;
      repeat (2) begin
         decode_tx_frame(data, found);
         if (exp_tx_q.size() == 0) begin
            $display("a frame appeared on tx with no accepted command behind it");
            errors++;
         end else begin
            exp = exp_tx_q.pop_front();
            if (found) begin
               check_val("tx data byte", data, exp);
            end
         end
      end
   endtask

   // Line encoder for rx. Each bit is held for CLKS_PER_BIT cycles.
   task automatic send_rx_frame(input logic [7:0] data, input bit bad_parity,
                                input bit bad_stop, input int gap);
      logic [FRAME_BITS-1:0] bits;
      int                    i;
      bits[0]   = 1'b0;
      bits[8:1] = data;
      bits[9]   = (count_ones(data) % 2 == 0) ^ bad_parity;
      bits[10]  = ~bad_stop;
      for (i = 0; i < FRAME_BITS; i++) begin
         rx_line = bits[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      rx_line = 1'b1;
      repeat (gap) @(negedge clk);
   endtask

   task automatic check_rx_events();
      rx_event_t exp;
      rx_event_t got;
      int        cycles;
      cycles = 0;
      while (got_rx_q.size() < exp_rx_q.size() && cycles < LINE_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (got_rx_q.size() < exp_rx_q.size()) begin
         $display("timeout waiting for read_rdy or read_err, %0d of %0d frames reported",
                  got_rx_q.size(), exp_rx_q.size());
         errors++;
      end
      repeat (FRAME_BITS * CLKS_PER_BIT) @(negedge clk); // Lets a stray pulse show up.
      check_val("receive pulse count", got_rx_q.size(), exp_rx_q.size());
      while (exp_rx_q.size() > 0 && got_rx_q.size() > 0) begin
         exp = exp_rx_q.pop_front();
         got = got_rx_q.pop_front();
         check_val("read_err", got.err, exp.err);
         if (!exp.err) begin
            check_val("read_data", got.data, exp.data);
         end
      end
      exp_rx_q.delete();
      got_rx_q.delete();
   endtask

   initial begin
      int          start;
      int          n;
      int          kind;
      logic [15:0] cmd;
      logic [7:0]  data;

      void'($urandom(SEED));
      clk      = 1'b0;
      rst_n    = 1'b0;
      cmd_in   = '0;
      cmd_vld  = 1'b0;
      rx_line  = 1'b1;
      loopback = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;

      start = errors;
      repeat (4) begin
         @(negedge clk);
         check_val("tx", tx, 1);
         check_val("cmd_rdy", cmd_rdy, 1);
         check_val("read_rdy", read_rdy, 0);
         check_val("read_err", read_err, 0);
         check_val("read_data", read_data, 0);
      end
      report_test("reset state", start);

      start = errors;
      for (n = 0; n < 50; n++) begin
         cmd = 16'($urandom);
         exp_tx_q.push_back(cmd[15:8]);
         exp_tx_q.push_back(cmd[7:0]);
         fork
            send_cmd(cmd, 1'b0);
            expect_cmd_frames();
         join
      end
      report_test("transmit framing", start);

      start = errors;
      for (n = 0; n < 10; n++) begin
         cmd = 16'($urandom);
         exp_tx_q.push_back(cmd[15:8]);
         exp_tx_q.push_back(cmd[7:0]);
         fork
            send_cmd(cmd, 1'b1);
            expect_cmd_frames();
         join
      end
      report_test("busy back-pressure", start);

      start = errors;
      for (n = 0; n < 50; n++) begin
         data = 8'($urandom);
         exp_rx_q.push_back({1'b0, data});
         if ($urandom_range(0, 2) == 0) begin
            send_rx_frame(data, 1'b0, 1'b0, 0);
         end else begin
            send_rx_frame(data, 1'b0, 1'b0, int'($urandom_range(1, 3 * CLKS_PER_BIT)));
         end
      end
      check_rx_events();
      report_test("receive good frames", start);

      // Bad frames get at least one idle bit so a low stop bit ends cleanly.
      start = errors;
      for (n = 0; n < 20; n++) begin
         kind = int'($urandom_range(0, 2));
         data = 8'($urandom);
         exp_rx_q.push_back({1'b1, data});
         send_rx_frame(data, kind != 1, kind != 0,
                       CLKS_PER_BIT * (1 + int'($urandom_range(0, 1))));
         data = 8'($urandom);
         exp_rx_q.push_back({1'b0, data});
         send_rx_frame(data, 1'b0, 1'b0, int'($urandom_range(0, 2 * CLKS_PER_BIT)));
      end
      check_rx_events();
      report_test("receive errors", start);

      start    = errors;
      loopback = 1'b1;
      for (n = 0; n < 20; n++) begin
         cmd = 16'($urandom);
         exp_rx_q.push_back({1'b0, cmd[15:8]});
         exp_rx_q.push_back({1'b0, cmd[7:0]});
         send_cmd(cmd, 1'b0);
      end
      check_rx_events();
      loopback = 1'b0;
      report_test("loopback", start);

      if (u_dut.u_assert.fail_cnt != 0) begin
         $display("%0d concurrent assertion failures in the bound checker",
                  u_dut.u_assert.fail_cnt);
         errors += u_dut.u_assert.fail_cnt;
      end

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- sources.f
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart.sv
testbench/uart_assert.sv
testbench/uart_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = uart_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "simulation reported a failure, see $(LOG)"; \
	   exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
